/* alu_backend_asserts.sv */
`timescale 1ns/1ps

module alu_backend_asserts (
    input logic              clk,
    input logic              rst,
    input logic              instr_valid_i,
    input logic              stall_o,
    input logic              wb_valid_o,
    input cpu_pkg::reg_idx_t wb_rd_o,
    input logic              exc_valid_o
);
    import cpu_pkg::*;

    // a stall only holds an instruction that is actually offered
    stall_needs_valid: assert property (
        @(posedge clk) disable iff (rst) stall_o |-> instr_valid_i
    ) else $error("stall_o high while instr_valid_i is low");

    wb_exc_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(wb_valid_o && exc_valid_o)
    ) else $error("wb_valid_o and exc_valid_o high in the same cycle");

    // register 0 writes never reach the writeback port
    wb_not_r0: assert property (
        @(posedge clk) disable iff (rst) wb_valid_o |-> (wb_rd_o != '0)
    ) else $error("writeback pulse for register 0");

    quiet_after_reset: assert property (
        @(posedge clk) rst |=> (!wb_valid_o && !exc_valid_o)
    ) else $error("result pulse in the cycle after reset");

endmodule

/* alu_backend_tb.sv */
`timescale 1ns/1ps

module alu_backend_tb;
    import cpu_pkg::*;

    localparam time CLK_PERIOD     = 40ns;
    // upper bound on the instructions issued by all tests
    localparam int  TEST_INSTRS    = 260;
    // a serial instruction needs four cycles
    localparam int  TIMEOUT_CYCLES = TEST_INSTRS * 10 + 100;

    localparam logic [5:0] R_FUNCTS [16] = '{
        FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU,
        FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU
    };
    localparam logic [5:0] I_OPCODES [8] = '{
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI
    };

    logic      clk;
    logic      rst;
    logic      instr_valid_i;
    word_t     instr_i;
    word_t     pc_i;
    logic      stall_o;
    logic      wb_valid_o;
    reg_idx_t  wb_rd_o;
    word_t     wb_data_o;
    logic      exc_valid_o;
    exc_code_t exc_code_o;
    word_t     exc_pc_o;
    word_t     retired_count_o;

    // reference model state
    word_t shadow [REG_COUNT];
    word_t exp_retired;
    word_t pc;
    word_t lfsr_state = 32'd67;

    alu_backend_top UUT (
        .clk             (clk),
        .rst             (rst),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .stall_o         (stall_o),
        .wb_valid_o      (wb_valid_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .exc_valid_o     (exc_valid_o),
        .exc_code_o      (exc_code_o),
        .exc_pc_o        (exc_pc_o),
        .retired_count_o (retired_count_o)
    );

    bind alu_backend_top alu_backend_asserts u_asserts (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .stall_o       (stall_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .exc_valid_o   (exc_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * TIMEOUT_CYCLES);
        abort_run($sformatf("run timed out after %0d clock cycles", TIMEOUT_CYCLES));
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_exc(input string name, input exc_code_t got, input exc_code_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic word_t lfsr_bits(input int count);
        word_t bits;
        int    i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return bits;
    endfunction

    function automatic reg_idx_t rand_reg();
        reg_idx_t r;
        r = reg_idx_t'(lfsr_bits(5));
        return (r == '0) ? reg_idx_t'(1) : r;
    endfunction

    function automatic word_t encode_r(input logic [5:0] fn, input reg_idx_t rs,
                                       input reg_idx_t rt, input reg_idx_t rd,
                                       input logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t encode_i(input logic [5:0] op, input reg_idx_t rs,
                                       input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t shift_right_arith(input word_t x, input logic [4:0] s);
        return (x >> s) | (x[31] ? ~(32'hffff_ffff >> s) : 32'h0);
    endfunction

    // true when the signed 32-bit sum or difference does not fit
    function automatic logic overflows(input word_t x, input word_t y, input logic subtract);
        longint sx;
        longint sy;
        longint r;
        sx = longint'($signed(x));
        sy = longint'($signed(y));
        r  = subtract ? (sx - sy) : (sx + sy);
        return (r > 64'sd2147483647) || (r < -64'sd2147483648);
    endfunction

    function automatic void predict(input word_t instr, output exc_code_t code,
                                    output reg_idx_t dest, output word_t val);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] sa;
        word_t      a;
        word_t      b;
        word_t      simm;
        word_t      zimm;
        op   = instr[31:26];
        fn   = instr[5:0];
        sa   = instr[10:6];
        a    = shadow[instr[25:21]];
        b    = shadow[instr[20:16]];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        code = EXC_NONE;
        dest = instr[20:16];
        val  = '0;
        if (op == OP_SPECIAL) begin
            dest = instr[15:11];
            case (fn)
                FN_SLL:          val = b << sa;
                FN_SRL:          val = b >> sa;
                FN_SRA:          val = shift_right_arith(b, sa);
                FN_SLLV:         val = b << a[4:0];
                FN_SRLV:         val = b >> a[4:0];
                FN_SRAV:         val = shift_right_arith(b, a[4:0]);
                FN_ADD, FN_ADDU: val = a + b;
                FN_SUB, FN_SUBU: val = a - b;
                FN_AND:          val = a & b;
                FN_OR:           val = a | b;
                FN_XOR:          val = a ^ b;
                FN_NOR:          val = ~(a | b);
                FN_SLT:          val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLTU:         val = (a < b) ? 32'd1 : 32'd0;
                default:         code = EXC_RI;
            endcase
            if (((fn == FN_ADD) && overflows(a, b, 1'b0)) ||
                ((fn == FN_SUB) && overflows(a, b, 1'b1))) begin
                code = EXC_OVF;
            end
        end else begin
            case (op)
                OP_ADDI: begin
                    val = a + simm;
                    if (overflows(a, simm, 1'b0)) begin
                        code = EXC_OVF;
                    end
                end
                OP_ADDIU: val = a + simm;
                OP_SLTI:  val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                OP_SLTIU: val = (a < simm) ? 32'd1 : 32'd0;
                OP_ANDI:  val = a & zimm;
                OP_ORI:   val = a | zimm;
                OP_XORI:  val = a ^ zimm;
                OP_LUI:   val = {instr[15:0], 16'h0000};
                default:  code = EXC_RI;
            endcase
        end
    endfunction

    // drive at a rising edge and return at the edge that accepts it
    task automatic issue(input word_t instr, input word_t instr_pc);
        instr_valid_i <= 1'b1;
        instr_i       <= instr;
        pc_i          <= instr_pc;
        @(negedge clk);
        while (stall_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        instr_valid_i <= 1'b0;
    endtask

    // called at the acceptance edge; the result is due two edges later
    task automatic expect_result(input word_t instr, input word_t instr_pc);
        exc_code_t code;
        reg_idx_t  dest;
        word_t     val;
        predict(instr, code, dest, val);
        repeat (2) begin
            @(negedge clk);
            check_flag("wb_valid_o", wb_valid_o, 1'b0);
            check_flag("exc_valid_o", exc_valid_o, 1'b0);
            @(posedge clk);
        end
        @(negedge clk);
        if (code != EXC_NONE) begin
            check_flag("exc_valid_o", exc_valid_o, 1'b1);
            check_flag("wb_valid_o", wb_valid_o, 1'b0);
            check_exc("exc_code_o", exc_code_o, code);
            check_word("exc_pc_o", exc_pc_o, instr_pc);
        end else begin
            exp_retired = exp_retired + 1;
            check_flag("exc_valid_o", exc_valid_o, 1'b0);
            check_flag("wb_valid_o", wb_valid_o, dest != '0);
            if (dest != '0) begin
                check_reg("wb_rd_o", wb_rd_o, dest);
                check_word("wb_data_o", wb_data_o, val);
                shadow[dest] = val;
            end
        end
        check_count("retired_count_o", retired_count_o, exp_retired);
        @(posedge clk);
    endtask

    task automatic run_instr(input word_t instr);
        issue(instr, pc);
        expect_result(instr, pc);
        pc = pc + 4;
    endtask

    task automatic load_reg(input reg_idx_t r, input word_t v);
        run_instr(encode_i(OP_LUI, 5'd0, r, v[31:16]));
        run_instr(encode_i(OP_ORI, r, r, v[15:0]));
    endtask

    task automatic test_alu_ops();
        reg_idx_t rs;
        reg_idx_t rt;
        int       round;
        int       i;
        for (round = 0; round < 2; round++) begin
            for (i = 0; i < 16; i++) begin
                rs = rand_reg();
                rt = rand_reg();
                load_reg(rs, lfsr_bits(32));
                load_reg(rt, lfsr_bits(32));
                run_instr(encode_r(R_FUNCTS[i], rs, rt, rand_reg(), 5'(lfsr_bits(5))));
            end
            for (i = 0; i < 8; i++) begin
                rs = rand_reg();
                load_reg(rs, lfsr_bits(32));
                run_instr(encode_i(I_OPCODES[i], rs, rand_reg(), 16'(lfsr_bits(16))));
            end
        end
    endtask

    // consumer offered in the cycle right after the producer is accepted
    task automatic raw_pair(input word_t prod, input word_t cons);
        exc_code_t code;
        reg_idx_t  dest;
        word_t     val;
        int        stalls;
        predict(prod, code, dest, val);
        issue(prod, pc);
        pc = pc + 4;
        instr_valid_i <= 1'b1;
        instr_i       <= cons;
        pc_i          <= pc;
        stalls = 0;
        @(negedge clk);
        check_flag("stall_o", stall_o, 1'b1);
        while (stall_o) begin
            stalls++;
            @(negedge clk);
        end
        // producer writes back in the cycle the stall drops
        check_flag("wb_valid_o", wb_valid_o, 1'b1);
        check_reg("wb_rd_o", wb_rd_o, dest);
        check_word("wb_data_o", wb_data_o, val);
        shadow[dest] = val;
        exp_retired  = exp_retired + 1;
        @(posedge clk);
        instr_valid_i <= 1'b0;
        check_count("stall cycles", stalls, 2);
        expect_result(cons, pc);
        pc = pc + 4;
    endtask

    task automatic test_raw_hazard();
        load_reg(5'd1, 32'h0000_1234);
        load_reg(5'd2, 32'h1111_0000);
        raw_pair(encode_r(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0),
                 encode_r(FN_XOR, 5'd2, 5'd3, 5'd4, 5'd0));
        raw_pair(encode_i(OP_ADDIU, 5'd4, 5'd6, 16'h0010),
                 encode_i(OP_SLTI, 5'd6, 5'd7, 16'h7fff));
    endtask

    task automatic test_overflow();
        load_reg(5'd5, 32'h7fff_ffff);
        load_reg(5'd6, 32'h0000_0001);
        load_reg(5'd7, 32'h1234_5678);
        load_reg(5'd9, 32'h8000_0000);
        run_instr(encode_r(FN_ADD, 5'd5, 5'd6, 5'd7, 5'd0));
        run_instr(encode_i(OP_ADDI, 5'd5, 5'd7, 16'h0001));
        run_instr(encode_r(FN_SUB, 5'd9, 5'd6, 5'd7, 5'd0));
        // r7 must still hold its loaded value
        run_instr(encode_r(FN_OR, 5'd7, 5'd0, 5'd8, 5'd0));
        run_instr(encode_r(FN_ADDU, 5'd5, 5'd6, 5'd7, 5'd0));
        run_instr(encode_i(OP_ADDIU, 5'd5, 5'd10, 16'h0001));
        run_instr(encode_r(FN_SUBU, 5'd9, 5'd6, 5'd11, 5'd0));
    endtask

    task automatic test_reserved();
        // a load word and an unused SPECIAL funct
        run_instr(encode_i(6'h23, 5'd1, 5'd2, 16'h0000));
        run_instr(encode_r(6'h01, 5'd1, 5'd2, 5'd3, 5'd0));
        run_instr(encode_i(6'h10, 5'd0, 5'd4, 16'hffff));
    endtask

    task automatic test_reg_zero();
        run_instr(encode_i(OP_ADDIU, 5'd1, 5'd0, 16'h0055));
        run_instr(encode_r(FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
        run_instr(encode_r(FN_OR, 5'd0, 5'd0, 5'd10, 5'd0));
        run_instr(encode_i(OP_XORI, 5'd0, 5'd11, 16'h0000));
    endtask

    initial begin
        int i;
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        pc            = 32'h0040_0000;
        exp_retired   = '0;
        for (i = 0; i < REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("stall_o", stall_o, 1'b0);
        check_flag("wb_valid_o", wb_valid_o, 1'b0);
        check_flag("exc_valid_o", exc_valid_o, 1'b0);
        check_count("retired_count_o", retired_count_o, '0);
        @(posedge clk);
        test_alu_ops();
        test_raw_hazard();
        test_overflow();
        test_reserved();
        test_reg_zero();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* alu_backend_top.sv */
`timescale 1ns/1ps

module alu_backend_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid_i,
    input  cpu_pkg::word_t     instr_i,
    input  cpu_pkg::word_t     pc_i,
    output logic               stall_o,
    output logic               wb_valid_o,
    output cpu_pkg::reg_idx_t  wb_rd_o,
    output cpu_pkg::word_t     wb_data_o,
    output logic               exc_valid_o,
    output cpu_pkg::exc_code_t exc_code_o,
    output cpu_pkg::word_t     exc_pc_o,
    output cpu_pkg::word_t     retired_count_o
);
    import cpu_pkg::*;

    // decode to execute
    logic     ex_valid;
    uop_t     ex_uop;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_pc;

    // register file ports
    reg_idx_t rf_ra;
    reg_idx_t rf_rb;
    word_t    rf_a;
    word_t    rf_b;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    // execute to result
    logic     res_valid;
    reg_idx_t res_rd;
    logic     res_writes;
    word_t    res_data;
    logic     res_ovf;
    logic     res_illegal;
    word_t    res_pc;

    logic     sb_clr;
    reg_idx_t sb_clr_idx;

    decode_stage u_decode_stage (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .clr_i         (sb_clr),
        .clr_idx_i     (sb_clr_idx),
        .rf_ra_o       (rf_ra),
        .rf_rb_o       (rf_rb),
        .rf_a_i        (rf_a),
        .rf_b_i        (rf_b),
        .stall_o       (stall_o),
        .ex_valid_o    (ex_valid),
        .ex_uop_o      (ex_uop),
        .ex_a_o        (ex_a),
        .ex_b_o        (ex_b),
        .ex_pc_o       (ex_pc)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .ra_i      (rf_ra),
        .rb_i      (rf_rb),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    execute_stage u_execute_stage (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (ex_valid),
        .uop_i         (ex_uop),
        .a_i           (ex_a),
        .b_i           (ex_b),
        .pc_i          (ex_pc),
        .res_valid_o   (res_valid),
        .res_rd_o      (res_rd),
        .res_writes_o  (res_writes),
        .res_data_o    (res_data),
        .res_ovf_o     (res_ovf),
        .res_illegal_o (res_illegal),
        .res_pc_o      (res_pc)
    );

    result_stage u_result_stage (
        .clk             (clk),
        .rst             (rst),
        .valid_i         (res_valid),
        .rd_i            (res_rd),
        .writes_i        (res_writes),
        .data_i          (res_data),
        .ovf_i           (res_ovf),
        .illegal_i       (res_illegal),
        .pc_i            (res_pc),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata),
        .sb_clr_o        (sb_clr),
        .sb_clr_idx_o    (sb_clr_idx),
        .wb_valid_o      (wb_valid_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .exc_valid_o     (exc_valid_o),
        .exc_code_o      (exc_code_o),
        .exc_pc_o        (exc_pc_o),
        .retired_count_o (retired_count_o)
    );

endmodule

/* alu_decode.sv */
`timescale 1ns/1ps

module alu_decode (
    input  cpu_pkg::word_t instr_i,
    output cpu_pkg::uop_t  uop_o
);
    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      imm_sext;
    word_t      imm_zext;

    assign opcode   = instr_i[31:26];
    assign funct    = instr_i[5:0];
    assign imm_sext = {{16{instr_i[15]}}, instr_i[15:0]};
    assign imm_zext = {16'h0000, instr_i[15:0]};

    always_comb begin
        uop_o          = '0;
        uop_o.rs       = instr_i[25:21];
        uop_o.rt       = instr_i[20:16];
        uop_o.rd       = instr_i[15:11];
        uop_o.shamt    = instr_i[10:6];
        uop_o.imm      = imm_sext;

        case (opcode)
            OP_SPECIAL: begin
                uop_o.writes_rd = 1'b1;
                uop_o.uses_rs   = 1'b1;
                uop_o.uses_rt   = 1'b1;
                case (funct)
                    FN_SLL:  uop_o.alu_op = ALU_SLL;
                    FN_SRL:  uop_o.alu_op = ALU_SRL;
                    FN_SRA:  uop_o.alu_op = ALU_SRA;
                    FN_SLLV: uop_o.alu_op = ALU_SLL;
                    FN_SRLV: uop_o.alu_op = ALU_SRL;
                    FN_SRAV: uop_o.alu_op = ALU_SRA;
                    FN_ADD:  uop_o.alu_op = ALU_ADD;
                    FN_ADDU: uop_o.alu_op = ALU_ADDU;
                    FN_SUB:  uop_o.alu_op = ALU_SUB;
                    FN_SUBU: uop_o.alu_op = ALU_SUBU;
                    FN_AND:  uop_o.alu_op = ALU_AND;
                    FN_OR:   uop_o.alu_op = ALU_OR;
                    FN_XOR:  uop_o.alu_op = ALU_XOR;
                    FN_NOR:  uop_o.alu_op = ALU_NOR;
                    FN_SLT:  uop_o.alu_op = ALU_SLT;
                    FN_SLTU: uop_o.alu_op = ALU_SLTU;
                    default: uop_o.illegal = 1'b1;
                endcase
                // fixed shifts take shamt, variable ones rs
                uop_o.shift_var = (funct == FN_SLLV) || (funct == FN_SRLV) || (funct == FN_SRAV);
                if ((funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA)) begin
                    uop_o.uses_rs = 1'b0;
                end
                uop_o.traps_ovf = (funct == FN_ADD) || (funct == FN_SUB);
            end
            OP_ADDI: begin
                uop_o.alu_op    = ALU_ADD;
                uop_o.traps_ovf = 1'b1;
            end
            OP_ADDIU: uop_o.alu_op = ALU_ADDU;
            OP_SLTI:  uop_o.alu_op = ALU_SLT;
            OP_SLTIU: uop_o.alu_op = ALU_SLTU;
            OP_ANDI: begin
                uop_o.alu_op = ALU_AND;
                uop_o.imm    = imm_zext;
            end
            OP_ORI: begin
                uop_o.alu_op = ALU_OR;
                uop_o.imm    = imm_zext;
            end
            OP_XORI: begin
                uop_o.alu_op = ALU_XOR;
                uop_o.imm    = imm_zext;
            end
            OP_LUI: begin
                uop_o.alu_op = ALU_LUI;
                uop_o.imm    = {instr_i[15:0], 16'h0000};
            end
            default: uop_o.illegal = 1'b1;
        endcase

        // i-type writes rt
        if (opcode != OP_SPECIAL) begin
            uop_o.rd        = instr_i[20:16];
            uop_o.src_imm   = 1'b1;
            uop_o.writes_rd = 1'b1;
            uop_o.uses_rs   = (opcode != OP_LUI);
        end

        if (uop_o.illegal) begin
            uop_o.writes_rd = 1'b0;
            uop_o.uses_rs   = 1'b0;
            uop_o.uses_rt   = 1'b0;
            uop_o.traps_ovf = 1'b0;
        end
    end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL funct field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_OVF  = 2'd1,
        EXC_RI   = 2'd2
    } exc_code_t;

    typedef struct packed {
        alu_op_t    alu_op;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic       writes_rd;
        logic       uses_rs;
        logic       uses_rt;
        logic       src_imm;
        word_t      imm;
        logic [4:0] shamt;
        logic       shift_var;
        logic       traps_ovf;
        logic       illegal;
    } uop_t;

endpackage

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid_i,
    input  cpu_pkg::word_t    instr_i,
    input  cpu_pkg::word_t    pc_i,
    input  logic              clr_i,
    input  cpu_pkg::reg_idx_t clr_idx_i,
    output cpu_pkg::reg_idx_t rf_ra_o,
    output cpu_pkg::reg_idx_t rf_rb_o,
    input  cpu_pkg::word_t    rf_a_i,
    input  cpu_pkg::word_t    rf_b_i,
    output logic              stall_o,
    output logic              ex_valid_o,
    output cpu_pkg::uop_t     ex_uop_o,
    output cpu_pkg::word_t    ex_a_o,
    output cpu_pkg::word_t    ex_b_o,
    output cpu_pkg::word_t    ex_pc_o
);
    import cpu_pkg::*;

    uop_t uop;
    logic rs_busy;
    logic rt_busy;
    logic rd_busy;
    logic hazard;
    logic accept;

    alu_decode u_alu_decode (
        .instr_i (instr_i),
        .uop_o   (uop)
    );

    scoreboard u_scoreboard (
        .clk       (clk),
        .rst       (rst),
        .set_i     (accept && uop.writes_rd),
        .set_idx_i (uop.rd),
        .clr_i     (clr_i),
        .clr_idx_i (clr_idx_i),
        .rs_idx_i  (uop.rs),
        .rt_idx_i  (uop.rt),
        .rd_idx_i  (uop.rd),
        .rs_busy_o (rs_busy),
        .rt_busy_o (rt_busy),
        .rd_busy_o (rd_busy)
    );

    // raw on either source, waw on the destination
    assign hazard = (uop.uses_rs && rs_busy) || (uop.uses_rt && rt_busy) ||
                    (uop.writes_rd && rd_busy);
    assign stall_o = instr_valid_i && hazard;
    assign accept  = instr_valid_i && !hazard;

    assign rf_ra_o = uop.rs;
    assign rf_rb_o = uop.rt;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_uop_o <= uop;
            ex_a_o   <= rf_a_i;
            ex_b_o   <= uop.src_imm ? uop.imm : rf_b_i;
            ex_pc_o  <= pc_i;
        end
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_i,
    input  cpu_pkg::uop_t     uop_i,
    input  cpu_pkg::word_t    a_i,
    input  cpu_pkg::word_t    b_i,
    input  cpu_pkg::word_t    pc_i,
    output logic              res_valid_o,
    output cpu_pkg::reg_idx_t res_rd_o,
    output logic              res_writes_o,
    output cpu_pkg::word_t    res_data_o,
    output logic              res_ovf_o,
    output logic              res_illegal_o,
    output cpu_pkg::word_t    res_pc_o
);
    import cpu_pkg::*;

    word_t      sum;
    word_t      diff;
    word_t      result;
    logic [4:0] sh;
    logic       add_ovf;
    logic       sub_ovf;
    logic       ovf;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;
    assign sh   = uop_i.shift_var ? a_i[4:0] : uop_i.shamt;

    // signed overflow from operand and result signs
    assign add_ovf = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
    assign sub_ovf = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
    assign ovf     = uop_i.traps_ovf && (((uop_i.alu_op == ALU_ADD) && add_ovf) ||
                                         ((uop_i.alu_op == ALU_SUB) && sub_ovf));

    always_comb begin
        case (uop_i.alu_op)
            ALU_ADD, ALU_ADDU: result = sum;
            ALU_SUB, ALU_SUBU: result = diff;
            ALU_AND:  result = a_i & b_i;
            ALU_OR:   result = a_i | b_i;
            ALU_XOR:  result = a_i ^ b_i;
            ALU_NOR:  result = ~(a_i | b_i);
            ALU_SLT:  result = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: result = {31'b0, a_i < b_i};
            ALU_SLL:  result = b_i << sh;
            ALU_SRL:  result = b_i >> sh;
            ALU_SRA:  result = $unsigned($signed(b_i) >>> sh);
            // immediate already shifted by the decoder
            ALU_LUI:  result = b_i;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            res_rd_o      <= uop_i.rd;
            res_writes_o  <= uop_i.writes_rd;
            res_data_o    <= result;
            res_ovf_o     <= ovf;
            res_illegal_o <= uop_i.illegal;
            res_pc_o      <= pc_i;
        end
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t ra_i,
    input  cpu_pkg::reg_idx_t rb_i,
    output cpu_pkg::word_t    rdata_a_o,
    output cpu_pkg::word_t    rdata_b_o,
    input  logic              we_i,
    input  cpu_pkg::reg_idx_t waddr_i,
    input  cpu_pkg::word_t    wdata_i
);
    import cpu_pkg::*;

    word_t regs [REG_COUNT];

    // write data forwarded so a reader on the write edge sees the new value
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (we_i && (waddr_i == idx)) begin
            return wdata_i;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = read_port(ra_i);
    assign rdata_b_o = read_port(rb_i);

endmodule

/* result_stage.sv */
`timescale 1ns/1ps

module result_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_i,
    input  cpu_pkg::reg_idx_t  rd_i,
    input  logic               writes_i,
    input  cpu_pkg::word_t     data_i,
    input  logic               ovf_i,
    input  logic               illegal_i,
    input  cpu_pkg::word_t     pc_i,
    output logic               rf_we_o,
    output cpu_pkg::reg_idx_t  rf_waddr_o,
    output cpu_pkg::word_t     rf_wdata_o,
    output logic               sb_clr_o,
    output cpu_pkg::reg_idx_t  sb_clr_idx_o,
    output logic               wb_valid_o,
    output cpu_pkg::reg_idx_t  wb_rd_o,
    output cpu_pkg::word_t     wb_data_o,
    output logic               exc_valid_o,
    output cpu_pkg::exc_code_t exc_code_o,
    output cpu_pkg::word_t     exc_pc_o,
    output cpu_pkg::word_t     retired_count_o
);
    import cpu_pkg::*;

    exc_code_t code;
    logic      wr_q;
    logic      clr_q;
    reg_idx_t  rd_q;
    word_t     data_q;

    // reserved instruction first
    assign code = illegal_i ? EXC_RI : (ovf_i ? EXC_OVF : EXC_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_q            <= 1'b0;
            clr_q           <= 1'b0;
            exc_valid_o     <= 1'b0;
            retired_count_o <= '0;
        end else begin
            wr_q        <= valid_i && writes_i && (code == EXC_NONE) && (rd_i != '0);
            // busy bit goes away even when the write is dropped
            clr_q       <= valid_i && writes_i;
            exc_valid_o <= valid_i && (code != EXC_NONE);
            if (valid_i && (code == EXC_NONE)) begin
                retired_count_o <= retired_count_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_q       <= rd_i;
        data_q     <= data_i;
        exc_code_o <= code;
        exc_pc_o   <= pc_i;
    end

    assign rf_we_o      = wr_q;
    assign rf_waddr_o   = rd_q;
    assign rf_wdata_o   = data_q;
    assign sb_clr_o     = clr_q;
    assign sb_clr_idx_o = rd_q;
    assign wb_valid_o   = wr_q;
    assign wb_rd_o      = rd_q;
    assign wb_data_o    = data_q;

endmodule

/* scoreboard.sv */
`timescale 1ns/1ps

module scoreboard (
    input  logic              clk,
    input  logic              rst,
    input  logic              set_i,
    input  cpu_pkg::reg_idx_t set_idx_i,
    input  logic              clr_i,
    input  cpu_pkg::reg_idx_t clr_idx_i,
    input  cpu_pkg::reg_idx_t rs_idx_i,
    input  cpu_pkg::reg_idx_t rt_idx_i,
    input  cpu_pkg::reg_idx_t rd_idx_i,
    output logic              rs_busy_o,
    output logic              rt_busy_o,
    output logic              rd_busy_o
);
    import cpu_pkg::*;

    logic [REG_COUNT-1:0] busy;

    // a clear on this edge already frees the register
    function automatic logic lookup(input reg_idx_t idx);
        return busy[idx] && !(clr_i && (clr_idx_i == idx));
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (clr_i) begin
                busy[clr_idx_i] <= 1'b0;
            end
            // set wins over a clear of the same index
            if (set_i && (set_idx_i != '0)) begin
                busy[set_idx_i] <= 1'b1;
            end
        end
    end

    assign rs_busy_o = lookup(rs_idx_i);
    assign rt_busy_o = lookup(rt_idx_i);
    assign rd_busy_o = lookup(rd_idx_i);

endmodule

/* sources.f */
cpu_pkg.sv
alu_decode.sv
scoreboard.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
alu_backend_top.sv
alu_backend_asserts.sv
alu_backend_tb.sv
